// File: mem_pkg.sv
/*
 * CPU-side definitions for the external memory block
 * Word and byte address types, port select encoding
 */

package mem_pkg;

	// ========================================================================
	// Widths seen by the CPU
	// ========================================================================

	localparam int word_w = 32;                  // CPU data word
	localparam int cpu_addr_w = 32;              // CPU byte address

	typedef logic [word_w-1:0]     word_t;       // One CPU word
	typedef logic [cpu_addr_w-1:0] cpu_addr_t;   // Byte address, only 23..2 used off chip

	// ========================================================================
	// Port select
	// ========================================================================

	// Which CPU port an access belongs to
	typedef enum logic {
		port_instr = 1'b0,                       // Instruction fetch, always a read
		port_data  = 1'b1                        // Data load or store
	} port_t;

endpackage

// File: sram_pkg.sv
/*
 * Pin-side definitions for the asynchronous pseudo-SRAM
 * Address and data widths, half selector, sequencer states
 */

package sram_pkg;

	localparam int sram_addr_w = 23;             // Half-word address pins 23..1
	localparam int half_w = 16;                  // Data pins

	// Part of the CPU byte address that selects an SRAM word
	localparam int word_addr_hi = 23;
	localparam int word_addr_lo = 2;

	typedef logic [sram_addr_w-1:0] sram_addr_t; // Value on the address pins
	typedef logic [half_w-1:0]      half_t;      // One half-word on the data pins

	// Which half of a word a phase moves, encoded as the address LSB
	typedef enum logic {
		half_upper = 1'b0,                       // Bits 31..16, even address, goes first
		half_lower = 1'b1                        // Bits 15..0, odd address, goes second
	} half_sel_t;

	// Half-word sequencer
	typedef enum logic [1:0] {
		seq_idle  = 2'd0,                        // No access in flight
		seq_upper = 2'd1,                        // Upper half phase
		seq_lower = 2'd2                         // Lower half phase
	} seq_state_t;

endpackage

// File: mod_access_decode.sv
/*
 * Access arbitration between instruction and data ports
 * Data ahead of instruction, one served flag per port
 */

`timescale 1ns/100ps

module mod_access_decode (
	input  logic              clk,
	input  logic              rst,
	input  logic              ie,         // Instruction request level
	input  logic              de,         // Data request level
	input  mem_pkg::cpu_addr_t iaddr,
	input  mem_pkg::cpu_addr_t daddr,
	input  logic              drw,        // Data write when high
	input  mem_pkg::word_t    din,
	input  logic              busy,       // Sequencer has an access in flight
	output logic              go,         // One-cycle start pulse
	output mem_pkg::port_t    acc_port,
	output logic              acc_write,
	output mem_pkg::cpu_addr_t acc_addr,
	output mem_pkg::word_t    acc_wdata,
	output logic              pending     // Some request still unserved
);

	logic served_i;                       // Instruction request already handled
	logic served_d;                       // Data request already handled
	logic req_i;
	logic req_d;
	logic sel_data;

	// Requests that still need an access
	assign req_i = ie && !served_i;
	assign req_d = de && !served_d;

	assign pending = req_i || req_d;
	assign go      = pending && !busy;    // Only start when the sequencer is free

	// Data wins over instruction
	assign sel_data = req_d;

	// Chosen access, captured by the sequencer on the go edge
	assign acc_port  = sel_data ? mem_pkg::port_data : mem_pkg::port_instr;
	assign acc_write = sel_data && drw;   // Fetches never write
	assign acc_addr  = sel_data ? daddr : iaddr;
	assign acc_wdata = din;

	// ========================================================================
	// Served flags, one per request episode
	// ========================================================================

	// Set when the port is accepted, cleared as soon as its level drops
	always_ff @(posedge clk) begin
		if (rst) begin
			served_i <= 1'b0;
			served_d <= 1'b0;
		end else begin
			served_d <= de && (served_d || (go && sel_data));
			served_i <= ie && (served_i || (go && !sel_data));
		end
	end

endmodule

// File: mod_sram_seq.sv
/*
 * Half-word sequencer for the asynchronous SRAM
 * Two timed phases per word, pin drive, read sampling
 */

`timescale 1ns/100ps

module mod_sram_seq #(
	parameter int wait_cycles = 3             // Clocks per half-word phase, 2 or more
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 go,
	input  mem_pkg::port_t       acc_port,
	input  logic                 acc_write,
	input  mem_pkg::cpu_addr_t   acc_addr,
	input  mem_pkg::word_t       acc_wdata,
	input  sram_pkg::half_t      sram_dq_in,
	output logic                 busy,
	output logic                 done,        // Last cycle of an access
	output logic                 half_valid,  // Read half sampled this cycle
	output sram_pkg::half_sel_t  half_sel,
	output mem_pkg::port_t       half_port,
	output sram_pkg::half_t      half_data,
	output sram_pkg::sram_addr_t sram_addr,
	output sram_pkg::half_t      sram_dq_out,
	output logic                 sram_dq_oe,
	output logic                 sram_we      // Active low
);

	localparam int cnt_w = $clog2(wait_cycles);
	localparam int wa_w = sram_pkg::word_addr_hi - sram_pkg::word_addr_lo + 1;

	sram_pkg::seq_state_t state;
	logic [cnt_w-1:0]     cnt;                // Cycle within the phase

	// Latched access
	logic [wa_w-1:0]      a_addr;             // SRAM word address
	mem_pkg::word_t       a_wdata;
	mem_pkg::port_t       a_port;
	logic                 a_write;

	// Current view, valid in the go cycle too
	logic                 launch;             // Go cycle, doubles as first upper cycle
	logic                 active;
	logic                 phase_last;
	logic [wa_w-1:0]      cur_addr;
	mem_pkg::word_t       cur_wdata;
	logic                 cur_write;
	sram_pkg::half_sel_t  cur_sel;

	// ========================================================================
	// Phase control
	// ========================================================================

	assign launch     = (state == sram_pkg::seq_idle) && go;
	assign active     = launch || busy;
	assign busy       = (state != sram_pkg::seq_idle);
	assign phase_last = busy && (cnt == cnt_w'(wait_cycles - 1));
	assign done       = (state == sram_pkg::seq_lower) && phase_last;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= sram_pkg::seq_idle;
			cnt   <= '0;
		end else begin
			case (state)
				sram_pkg::seq_idle: begin
					if (go) begin
						state <= sram_pkg::seq_upper;
						cnt   <= cnt_w'(1);       // Go cycle counts as upper cycle 0
					end
				end
				sram_pkg::seq_upper: begin
					if (phase_last) begin
						state <= sram_pkg::seq_lower;
						cnt   <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				sram_pkg::seq_lower: begin
					if (phase_last) begin
						state <= sram_pkg::seq_idle;  // Word finished
						cnt   <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= sram_pkg::seq_idle;
			endcase
		end
	end

	// Access fields held for the whole word
	always_ff @(posedge clk) begin
		if (launch) begin
			a_addr  <= acc_addr[sram_pkg::word_addr_hi:sram_pkg::word_addr_lo];
			a_wdata <= acc_wdata;
			a_port  <= acc_port;
			a_write <= acc_write;
		end
	end

	// ========================================================================
	// Pin drive
	// ========================================================================

	assign cur_addr  = launch ? acc_addr[sram_pkg::word_addr_hi:sram_pkg::word_addr_lo] : a_addr;
	assign cur_wdata = launch ? acc_wdata : a_wdata;
	assign cur_write = launch ? acc_write : a_write;
	assign cur_sel   = (state == sram_pkg::seq_lower) ? sram_pkg::half_lower
	                                                  : sram_pkg::half_upper;

	assign sram_addr   = {cur_addr, (cur_sel == sram_pkg::half_lower)};  // LSB picks the half
	assign sram_dq_out = (cur_sel == sram_pkg::half_upper) ? cur_wdata[31:16] : cur_wdata[15:0];
	assign sram_dq_oe  = active && cur_write;   // Whole phase on writes
	assign sram_we     = !(active && cur_write && !phase_last);  // Rises on the last cycle

	// Read sample at the end of each phase
	assign half_valid = phase_last && !a_write;
	assign half_sel   = cur_sel;
	assign half_port  = a_port;
	assign half_data  = sram_dq_in;

endmodule

// File: mod_read_return.sv
/*
 * Read word assembly
 * Upper half staging, held result registers per port
 */

`timescale 1ns/100ps

module mod_read_return (
	input  logic                clk,
	input  logic                rst,
	input  logic                half_valid,  // Half-word sampled this cycle
	input  sram_pkg::half_sel_t half_sel,
	input  mem_pkg::port_t      half_port,
	input  sram_pkg::half_t     half_data,
	input  logic                done,        // Closing cycle of the word
	output mem_pkg::word_t      iout,
	output mem_pkg::word_t      dout
);

	sram_pkg::half_t upper_q;                // Upper half waiting for its partner
	mem_pkg::word_t  word;
	logic            load;

	assign word = {upper_q, half_data};
	// Lower half on the closing cycle completes the word
	assign load = half_valid && done && (half_sel == sram_pkg::half_lower);

	// Staging register
	always_ff @(posedge clk) begin
		if (half_valid && (half_sel == sram_pkg::half_upper))
			upper_q <= half_data;
	end

	// ========================================================================
	// Result registers, held until the next read on the same port
	// ========================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			iout <= '0;
			dout <= '0;
		end else if (load) begin
			if (half_port == mem_pkg::port_data)
				dout <= word;
			else
				iout <= word;                    // Other port keeps its value
		end
	end

endmodule

// File: mod_sram.sv
/*
 * External memory block top level
 * Arbitration, half-word sequencer, read return, static pins
 */

`timescale 1ns/100ps

module mod_sram #(
	parameter int wait_cycles = 3             // Clocks per half-word phase
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 ie,
	input  logic                 de,
	input  mem_pkg::cpu_addr_t   iaddr,
	input  mem_pkg::cpu_addr_t   daddr,
	input  logic                 drw,
	input  mem_pkg::word_t       din,
	input  sram_pkg::half_t      sram_dq_in,
	output mem_pkg::word_t       iout,
	output mem_pkg::word_t       dout,
	output logic                 cpu_stall,
	output logic                 sram_clk,
	output logic                 sram_adv,
	output logic                 sram_cre,
	output logic                 sram_ce,
	output logic                 sram_oe,
	output logic                 sram_lb,
	output logic                 sram_ub,
	output logic                 sram_we,
	output sram_pkg::sram_addr_t sram_addr,
	output sram_pkg::half_t      sram_dq_out,
	output logic                 sram_dq_oe
);

	// Decode to sequencer
	logic                go;
	mem_pkg::port_t      acc_port;
	logic                acc_write;
	mem_pkg::cpu_addr_t  acc_addr;
	mem_pkg::word_t      acc_wdata;
	logic                pending;
	logic                busy;

	// Sequencer to read return
	logic                done;
	logic                half_valid;
	sram_pkg::half_sel_t half_sel;
	mem_pkg::port_t      half_port;
	sram_pkg::half_t     half_data;

	// ========================================================================
	// Static SRAM pins, asynchronous mode
	// ========================================================================

	assign sram_clk = 1'b0;
	assign sram_adv = 1'b0;
	assign sram_cre = 1'b0;
	assign sram_ce  = 1'b0;
	assign sram_oe  = 1'b0;                // A low sram_we takes priority
	assign sram_lb  = 1'b0;                // Both byte lanes always on
	assign sram_ub  = 1'b0;

	// Stall from the first request cycle until the word is done
	assign cpu_stall = pending || busy;

	mod_access_decode u_decode (
		.clk       (clk),
		.rst       (rst),
		.ie        (ie),
		.de        (de),
		.iaddr     (iaddr),
		.daddr     (daddr),
		.drw       (drw),
		.din       (din),
		.busy      (busy),
		.go        (go),
		.acc_port  (acc_port),
		.acc_write (acc_write),
		.acc_addr  (acc_addr),
		.acc_wdata (acc_wdata),
		.pending   (pending)
	);

	mod_sram_seq #(
		.wait_cycles (wait_cycles)
	) u_seq (
		.clk         (clk),
		.rst         (rst),
		.go          (go),
		.acc_port    (acc_port),
		.acc_write   (acc_write),
		.acc_addr    (acc_addr),
		.acc_wdata   (acc_wdata),
		.sram_dq_in  (sram_dq_in),
		.busy        (busy),
		.done        (done),
		.half_valid  (half_valid),
		.half_sel    (half_sel),
		.half_port   (half_port),
		.half_data   (half_data),
		.sram_addr   (sram_addr),
		.sram_dq_out (sram_dq_out),
		.sram_dq_oe  (sram_dq_oe),
		.sram_we     (sram_we)
	);

	mod_read_return u_return (
		.clk        (clk),
		.rst        (rst),
		.half_valid (half_valid),
		.half_sel   (half_sel),
		.half_port  (half_port),
		.half_data  (half_data),
		.done       (done),
		.iout       (iout),
		.dout       (dout)
	);

endmodule

// File: tb_sram_model.sv
/*
 * Behavioral asynchronous 16-bit SRAM for the testbench
 * Combinational read, write on the rising edge of the write strobe
 */

`timescale 1ns/100ps

module tb_sram_model (
	input  logic                 sram_ce,      // Chip enable, active low
	input  logic                 sram_we,      // Write strobe, active low
	input  sram_pkg::sram_addr_t sram_addr,
	input  sram_pkg::half_t      sram_dq_out,  // Data from the DUT
	input  logic                 sram_dq_oe,   // DUT drives the data pins
	output sram_pkg::half_t      sram_dq_in    // Data back to the DUT
);

	localparam int depth = 1 << sram_pkg::sram_addr_w;

	sram_pkg::half_t mem [depth];              // One entry per half-word address

	// ========================================================================
	// Power-up contents
	// ========================================================================

	// Every address bit feeds the pattern, so stale reads are easy to spot
	initial begin
		for (int i = 0; i < depth; i++) begin
			mem[i] = sram_pkg::half_t'(i ^ (i >> 16) ^ 32'h0000_a5c3);
		end
	end

	// ========================================================================
	// Array access
	// ========================================================================

	// Read path follows the address pins with no clock
	assign sram_dq_in = mem[sram_addr];

	// Address and data are taken as the strobe goes high
	always @(posedge sram_we) begin
		if (!sram_ce && sram_dq_oe)
			mem[sram_addr] <= sram_dq_out;
	end

endmodule

// File: tb_checker.sv
/*
 * Testbench checker for the external memory block
 * Reference word memory, result model, stall length, write pin order, static pins
 */

`timescale 1ns/100ps

module tb_checker #(
	parameter int wait_cycles = 3
) (
	input  logic                 clk,
	input  logic                 rst,
	input  int                   test_id,      // Selects the name in error lines
	input  logic                 ie,
	input  logic                 de,
	input  mem_pkg::cpu_addr_t   iaddr,
	input  mem_pkg::cpu_addr_t   daddr,
	input  logic                 drw,
	input  mem_pkg::word_t       din,
	input  mem_pkg::word_t       iout,
	input  mem_pkg::word_t       dout,
	input  logic                 cpu_stall,
	input  logic                 sram_clk,
	input  logic                 sram_adv,
	input  logic                 sram_cre,
	input  logic                 sram_ce,
	input  logic                 sram_oe,
	input  logic                 sram_lb,
	input  logic                 sram_ub,
	input  logic                 sram_we,
	input  sram_pkg::sram_addr_t sram_addr,
	input  sram_pkg::half_t      sram_dq_out,
	input  logic                 sram_dq_oe,
	output int                   checks,
	output int                   errors
);

	mem_pkg::word_t     ref_mem [int unsigned];  // Words keyed by address bits 23..2
	logic               stall_q;
	logic               we_q;
	logic               rst_q;
	int                 run;                     // Stall cycles in this episode
	int                 pulses;                  // Write strobe pulses seen
	int                 we_low;                  // Cycles with the strobe low
	logic               c_i;                     // Captured request at stall start
	logic               c_d;
	logic               c_wr;
	mem_pkg::cpu_addr_t c_iaddr;
	mem_pkg::cpu_addr_t c_daddr;
	mem_pkg::word_t     c_din;
	mem_pkg::word_t     exp_iout;                // Word each port should hold
	mem_pkg::word_t     exp_dout;

	function automatic string test_label(int id);
		case (id)
			0:       return "reset";
			1:       return "write_read";
			2:       return "fetch";
			3:       return "dual";
			default: return "unknown";
		endcase
	endfunction

	function automatic int unsigned word_index(mem_pkg::cpu_addr_t a);
		return {10'b0, a[23:2]};
	endfunction

	task automatic compare_word(string what, logic [31:0] exp, logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("MISMATCH %s %s expected %h actual %h", test_label(test_id), what,
				exp, act);
		end
	endtask

	task automatic compare_count(string what, int exp, int act);
		checks++;
		if (act != exp) begin
			errors++;
			$display("MISMATCH %s %s expected %0d actual %0d", test_label(test_id), what,
				exp, act);
		end
	endtask

	// New read result becomes the word the port holds from now on
	task automatic check_read(string what, mem_pkg::cpu_addr_t a, mem_pkg::word_t act,
			inout mem_pkg::word_t held);
		if (ref_mem.exists(word_index(a))) begin
			held = ref_mem[word_index(a)];
			compare_word(what, held, act);
		end else begin
			errors++;
			$display("%s: %s read from address %h, which was never written",
				test_label(test_id), what, a);
		end
	endtask

	// Results are settled on the closing cycle of a stall episode
	task automatic finish_access();
		compare_count("stall cycles", (c_i && c_d) ? 4 * wait_cycles : 2 * wait_cycles, run);
		if (c_wr) begin
			compare_count("write strobe pulses", 2, pulses);
			compare_count("write strobe low cycles", 2 * (wait_cycles - 1), we_low);
			ref_mem[word_index(c_daddr)] = c_din;  // Data goes before the fetch
		end
		if (c_d && !c_wr)
			check_read("dout", c_daddr, dout, exp_dout);
		else
			compare_word("dout held", exp_dout, dout);
		if (c_i)
			check_read("iout", c_iaddr, iout, exp_iout);
		else
			compare_word("iout held", exp_iout, iout);
		c_wr = 1'b0;
	endtask

	initial begin
		checks = 0;
		errors = 0;
		rst_q  = 1'b0;
		c_wr   = 1'b0;
	end

	// ========================================================================
	// Sampling on the falling edge where all DUT signals are settled
	// ========================================================================

	always @(negedge clk) begin
		if (rst) begin
			stall_q  = 1'b0;
			we_q     = 1'b1;
			run      = 0;
			exp_iout = '0;
			exp_dout = '0;
		end else begin
			if (rst_q) begin                     // First cycle out of reset
				compare_count("cpu_stall", 0, cpu_stall);
				compare_count("sram_we", 1, sram_we);
				compare_count("sram_dq_oe", 0, sram_dq_oe);
				compare_word("iout", 32'h0, iout);
				compare_word("dout", 32'h0, dout);
			end
			// Asynchronous mode pins stay tied low
			compare_count("static pins", 0,
				{sram_clk, sram_adv, sram_cre, sram_ce, sram_oe, sram_lb, sram_ub});
			if (cpu_stall && !stall_q) begin
				run     = 0;
				pulses  = 0;
				we_low  = 0;
				c_i     = ie;
				c_d     = de;
				c_wr    = de && drw;
				c_iaddr = iaddr;
				c_daddr = daddr;
				c_din   = din;
			end
			if (cpu_stall)
				run++;
			if (c_wr && cpu_stall) begin
				compare_count("write sram_dq_oe", 1, sram_dq_oe);  // Driven for both phases
				// Upper half at the even address first, then lower half at the odd one
				if (!sram_we) begin
					we_low++;
					if (we_q)
						pulses++;
					compare_word("sram_addr", {9'b0, c_daddr[23:2], pulses == 2},
						{9'b0, sram_addr});
					compare_word("sram_dq_out",
						(pulses == 1) ? {16'b0, c_din[31:16]} : {16'b0, c_din[15:0]},
						{16'b0, sram_dq_out});
				end
			end else begin
				compare_count("sram_we outside write", 1, sram_we);
				compare_count("sram_dq_oe outside write", 0, sram_dq_oe);
			end
			if (!cpu_stall && stall_q)
				finish_access();
			stall_q = cpu_stall;
			we_q    = sram_we;
		end
		rst_q = rst;
	end

endmodule

// File: tb_mod_sram.sv
/*
 * Testbench top for the external memory block
 * Clock, reset, seeded random accesses, test sequence, watchdog
 */

`timescale 1ns/100ps

module tb_mod_sram;

	localparam int wait_cycles = 3;
	localparam int clk_period = 40;
	localparam int n_write = 40;             // Writes, then as many reads
	localparam int n_fetch = 20;
	localparam int n_dual = 10;              // Fetch and load raised together
	localparam int n_access = 2 * n_write + n_fetch + 2 * n_dual;
	localparam int budget_ns = (n_access * 4 * wait_cycles + 200) * clk_period;
	localparam int wait_limit = 8 * wait_cycles;  // Cycles one stall may last

	logic                 clk;
	logic                 rst;
	logic                 ie;
	logic                 de;
	mem_pkg::cpu_addr_t   iaddr;
	mem_pkg::cpu_addr_t   daddr;
	logic                 drw;
	mem_pkg::word_t       din;
	mem_pkg::word_t       iout;
	mem_pkg::word_t       dout;
	logic                 cpu_stall;
	logic                 sram_clk;
	logic                 sram_adv;
	logic                 sram_cre;
	logic                 sram_ce;
	logic                 sram_oe;
	logic                 sram_lb;
	logic                 sram_ub;
	logic                 sram_we;
	sram_pkg::sram_addr_t sram_addr;
	sram_pkg::half_t      sram_dq_in;
	sram_pkg::half_t      sram_dq_out;
	logic                 sram_dq_oe;
	int                   test_id;
	int                   checks;
	int                   errors;
	int                   drive_errors;      // Accesses whose stall never dropped
	int                   checks_base;
	int                   fails_base;
	mem_pkg::cpu_addr_t   addrs [n_write];   // Addresses written in test 1

	mod_sram #(.wait_cycles(wait_cycles)) u_dut (
		.clk(clk), .rst(rst), .ie(ie), .de(de), .iaddr(iaddr), .daddr(daddr),
		.drw(drw), .din(din), .sram_dq_in(sram_dq_in), .iout(iout), .dout(dout),
		.cpu_stall(cpu_stall), .sram_clk(sram_clk), .sram_adv(sram_adv),
		.sram_cre(sram_cre), .sram_ce(sram_ce), .sram_oe(sram_oe), .sram_lb(sram_lb),
		.sram_ub(sram_ub), .sram_we(sram_we), .sram_addr(sram_addr),
		.sram_dq_out(sram_dq_out), .sram_dq_oe(sram_dq_oe)
	);

	tb_sram_model u_sram_model (
		.sram_ce(sram_ce), .sram_we(sram_we), .sram_addr(sram_addr),
		.sram_dq_out(sram_dq_out), .sram_dq_oe(sram_dq_oe), .sram_dq_in(sram_dq_in)
	);

	tb_checker #(.wait_cycles(wait_cycles)) u_checker (
		.clk(clk), .rst(rst), .test_id(test_id), .ie(ie), .de(de), .iaddr(iaddr),
		.daddr(daddr), .drw(drw), .din(din), .iout(iout), .dout(dout),
		.cpu_stall(cpu_stall), .sram_clk(sram_clk), .sram_adv(sram_adv),
		.sram_cre(sram_cre), .sram_ce(sram_ce), .sram_oe(sram_oe), .sram_lb(sram_lb),
		.sram_ub(sram_ub), .sram_we(sram_we), .sram_addr(sram_addr),
		.sram_dq_out(sram_dq_out), .sram_dq_oe(sram_dq_oe),
		.checks(checks), .errors(errors)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// Hard stop well past the longest possible run
	initial begin
		#(budget_ns);
		$display("Watchdog expired after %0d ns, the test sequence did not complete", budget_ns);
		$display("TEST FAILED");
		$finish;
	end

	// Wait on the falling edge for the stall to drop
	task automatic wait_release();
		int n;
		n = 0;
		@(negedge clk);
		while (cpu_stall && n < wait_limit) begin
			@(negedge clk);
			n++;
		end
		if (cpu_stall) begin
			$display("cpu_stall still high after %0d cycles, access abandoned", wait_limit);
			drive_errors++;
		end
	endtask

	task automatic data_access(input logic write, input mem_pkg::cpu_addr_t a,
			input mem_pkg::word_t d);
		@(posedge clk);
		de    <= 1'b1;
		drw   <= write;
		daddr <= a;
		din   <= d;
		wait_release();
		@(posedge clk);
		de  <= 1'b0;
		drw <= 1'b0;
	endtask

	task automatic fetch(input mem_pkg::cpu_addr_t a);
		@(posedge clk);
		ie    <= 1'b1;
		iaddr <= a;
		wait_release();
		@(posedge clk);
		ie <= 1'b0;
	endtask

	task automatic dual_access(input mem_pkg::cpu_addr_t fetch_addr,
			input mem_pkg::cpu_addr_t load_addr);
		@(posedge clk);
		ie    <= 1'b1;
		de    <= 1'b1;
		drw   <= 1'b0;
		iaddr <= fetch_addr;
		daddr <= load_addr;
		wait_release();
		@(posedge clk);
		ie <= 1'b0;
		de <= 1'b0;
	endtask

	task automatic report_test(input string name);
		$display("test %s done: %0d checks, %0d failures", name, checks - checks_base,
			errors + drive_errors - fails_base);
		checks_base = checks;
		fails_base  = errors + drive_errors;
	endtask

	// ========================================================================
	// Test sequence
	// ========================================================================

	initial begin
		int j;
		mem_pkg::cpu_addr_t tmp;
		rst = 1'b1;
		ie = 1'b0;
		de = 1'b0;
		drw = 1'b0;
		iaddr = '0;
		daddr = '0;
		din = '0;
		test_id = 0;
		drive_errors = 0;
		checks_base = 0;
		fails_base = 0;
		void'($urandom(43));
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		repeat (3) @(posedge clk);
		report_test("reset");

		test_id = 1;
		for (int i = 0; i < n_write; i++) begin
			addrs[i] = $urandom;
			data_access(1'b1, addrs[i], $urandom);
		end
		for (int i = n_write - 1; i > 0; i--) begin  // Shuffle for the read back
			j = $urandom_range(i, 0);
			tmp = addrs[i];
			addrs[i] = addrs[j];
			addrs[j] = tmp;
		end
		for (int i = 0; i < n_write; i++)
			data_access(1'b0, addrs[i], $urandom);
		report_test("write_read");

		test_id = 2;
		for (int i = 0; i < n_fetch; i++)
			fetch(addrs[$urandom_range(n_write - 1, 0)]);
		report_test("fetch");

		test_id = 3;
		for (int i = 0; i < n_dual; i++)
			dual_access(addrs[$urandom_range(n_write - 1, 0)],
				addrs[$urandom_range(n_write - 1, 0)]);
		report_test("dual");

		repeat (2) @(posedge clk);
		$display("all tests: %0d checks, %0d errors, %0d abandoned accesses",
			checks, errors, drive_errors);
		if (errors == 0 && drive_errors == 0 && checks > 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: all.f
mem_pkg.sv
sram_pkg.sv
mod_access_decode.sv
mod_sram_seq.sv
mod_read_return.sv
mod_sram.sv
tb_sram_model.sv
tb_checker.sv
tb_mod_sram.sv

// File: run.sh
#!/bin/sh
# Build and run the external memory block testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f all.f --top-module tb_mod_sram -o sim_tb_mod_sram
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

out=$(./obj_dir/sim_tb_mod_sram)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST OK"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1
